// File: list.f
hw/sifhPkg.sv
hw/ramBusIf.sv
hw/histRam.sv
hw/ramArbiter.sv
hw/histAccumulator.sv
hw/peakFinder.sv
hw/thresholdCalc.sv
hw/sifhTop.sv
tb/sifhTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= sifhTb
FILELIST ?= list.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert
PASS_TEXT ?= Regression passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from the search for the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: tb/sifhTb.sv
module sifhTb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NB = sifhPkg::nb;
    localparam int NP = sifhPkg::np;
    localparam int PIXELS = sifhPkg::pixelNum;
    localparam int PIXEL_W = $clog2(PIXELS);
    localparam int BINS = 2 ** NB;
    localparam int COUNT_MAX = 2 ** sifhPkg::countW - 1;
    localparam int SB = 2 ** (NB - 1) + 2 ** (NB - 2);     // half window width
    localparam int MAX_VAL = 2 ** NP - 1;
    localparam int EVENT_LIMIT = 64;                      // cycles for one increment
    localparam int FRAME_LIMIT = 4000;                    // cycles for a whole scan

    logic clk;
    logic res;
    logic eventValid;
    logic [PIXEL_W-1:0] eventPixel;
    logic [NB-1:0] eventBin;
    logic busy;
    logic frameEnd;
    logic resultValid;
    logic [PIXEL_W-1:0] resultPixel;
    logic [NP-1:0] thMinus;
    logic [NP-1:0] thPlus;
    logic [NP-1:0] delta;
    logic frameDone;

    int shadow [PIXELS][BINS];      // model histogram of the frame being filled
    logic [NP-1:0] expMinus [PIXELS];
    logic [NP-1:0] expPlus [PIXELS];
    logic [NP-1:0] expDelta [PIXELS];
    logic checkOn;                  // low for the clearing frame
    logic frameStart;
    logic [PIXELS-1:0] seenMask;    // pixels that reported in this frame
    logic doneSeen;
    int checkErrors;
    int timeouts;
    int seed;

    sifhTop #(.NB(NB), .NP(NP), .PIXEL_NUM(PIXELS), .COUNT_W(sifhPkg::countW)) dut0 (
        .clk(clk), .res(res), .eventValid(eventValid), .eventPixel(eventPixel),
        .eventBin(eventBin), .busy(busy), .frameEnd(frameEnd), .resultValid(resultValid),
        .resultPixel(resultPixel), .thMinus(thMinus), .thPlus(thPlus), .delta(delta),
        .frameDone(frameDone)
    );

    always #2 clk = ~clk;

    // per-frame bookkeeping of results
    always @(posedge clk or negedge res) begin
        if (!res) begin
            seenMask <= '0;
            doneSeen <= 1'b0;
        end else if (frameStart) begin
            seenMask <= '0;
            doneSeen <= 1'b0;
        end else begin
            if (resultValid) seenMask[resultPixel] <= 1'b1;
            if (frameDone) doneSeen <= 1'b1;
        end
    end

    assert property (@(posedge clk) disable iff (!res)
        (resultValid && checkOn) |-> thMinus == expMinus[resultPixel])
        else begin
            checkErrors++;
            $display("[FAIL] thMinus pixel %h: got %h, expected %h", $sampled(resultPixel),
                $sampled(thMinus), expMinus[$sampled(resultPixel)]);
        end

    assert property (@(posedge clk) disable iff (!res)
        (resultValid && checkOn) |-> thPlus == expPlus[resultPixel])
        else begin
            checkErrors++;
            $display("[FAIL] thPlus pixel %h: got %h, expected %h", $sampled(resultPixel),
                $sampled(thPlus), expPlus[$sampled(resultPixel)]);
        end

    assert property (@(posedge clk) disable iff (!res)
        (resultValid && checkOn) |-> delta == expDelta[resultPixel])
        else begin
            checkErrors++;
            $display("[FAIL] delta pixel %h: got %h, expected %h", $sampled(resultPixel),
                $sampled(delta), expDelta[$sampled(resultPixel)]);
        end

    // result timing against the internal peak strobe
    assert property (@(posedge clk) disable iff (!res) dut0.peakDone |=> resultValid)
        else begin
            checkErrors++;
            $display("resultValid did not follow peakDone after one cycle");
        end

    assert property (@(posedge clk) disable iff (!res) resultValid |-> $past(dut0.peakDone))
        else begin
            checkErrors++;
            $display("resultValid came without a peakDone in the cycle before");
        end

    // busy covers the read and the write of an accepted event
    assert property (@(posedge clk) disable iff (!res)
        (eventValid && !busy) |=> busy ##1 busy)
        else begin
            checkErrors++;
            $display("busy did not stay high through the increment of an event");
        end

    assert property (@(posedge clk) disable iff (!res) resultValid |-> !seenMask[resultPixel])
        else begin
            checkErrors++;
            $display("pixel %0d reported twice in one frame", $sampled(resultPixel));
        end

    assert property (@(posedge clk) disable iff (!res) frameDone |-> seenMask == '1)
        else begin
            checkErrors++;
            $display("frameDone came before every pixel had reported");
        end

    assert property (@(posedge clk) disable iff (!res) frameDone |-> $past(resultValid))
        else begin
            checkErrors++;
            $display("frameDone did not follow the last result by one cycle");
        end

    // lowest bin with the largest count
    function automatic int peakBin(input int pix);
        int best;
        int b;
        best = 0;
        for (b = 1; b < BINS; b++) begin
            if (shadow[pix][b] > shadow[pix][best]) best = b;  // strict, ties keep the lower bin
        end
        return best;
    endfunction

    function automatic void windowFor(input int bin, output int lo, output int hi);
        int ch;
        ch = bin << (NP - NB);
        if (ch <= SB) begin
            lo = 0;
            hi = 2 * SB;
        end else if (ch >= MAX_VAL - SB) begin
            hi = MAX_VAL;
            lo = MAX_VAL - 2 * SB;
        end else begin
            lo = ch - SB;
            hi = ch + SB;
        end
    endfunction

    // called right after a rising edge, returns after busy has fallen
    task automatic sendEvent(input int pix, input int bin);
        int n;
        eventValid <= 1'b1;
        eventPixel <= PIXEL_W'(pix);
        eventBin <= NB'(bin);
        @(posedge clk);
        eventValid <= 1'b0;
        if (shadow[pix][bin] < COUNT_MAX) shadow[pix][bin] = shadow[pix][bin] + 1;
        n = 0;
        @(posedge clk);
        while (busy && n < EVENT_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (busy) begin
            timeouts++;
            $display("timeout: busy stayed high after an event on pixel %0d", pix);
        end
    endtask

    // closes the frame, optionally feeding pixel 0 of the next frame during the scan
    task automatic runFrame(input logic check, input logic inject);
        int p;
        int b;
        int lo;
        int hi;
        int n;
        for (p = 0; p < PIXELS; p++) begin
            windowFor(peakBin(p), lo, hi);
            expMinus[p] = NP'(lo);
            expPlus[p] = NP'(hi);
            expDelta[p] = NP'((lo + hi) / 2);
            for (b = 0; b < BINS; b++) shadow[p][b] = 0;
        end
        checkOn = check;
        frameEnd <= 1'b1;
        frameStart <= 1'b1;
        @(posedge clk);
        frameEnd <= 1'b0;
        frameStart <= 1'b0;
        @(posedge clk);
        if (inject) begin
            repeat (6) @(posedge clk);
            frameEnd <= 1'b1;           // mid-scan pulse, scanner ignores it
            @(posedge clk);
            frameEnd <= 1'b0;
            n = 0;
            while (!seenMask[0] && n < FRAME_LIMIT) begin
                @(posedge clk);
                n++;
            end
            if (!seenMask[0]) begin
                timeouts++;
                $display("timeout: pixel 0 never reported during the scan");
                return;
            end
            // pixel 0 is cleared already, so these land in the next frame
            for (n = 0; n < 24 && timeouts == 0; n++) begin
                sendEvent(0, $unsigned($random(seed)) % BINS);
            end
        end
        n = 0;
        while (!doneSeen && n < FRAME_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (!doneSeen) begin
            timeouts++;
            $display("timeout: frameDone never arrived");
        end
    endtask

    task automatic runTests();
        int i;
        int pix;
        int bin;
        runFrame(1'b0, 1'b0);           // RAM content after power-up is unknown
        if (timeouts != 0) return;
        for (i = 0; i < 320 && timeouts == 0; i++) begin
            pix = $unsigned($random(seed)) % PIXELS;
            bin = $unsigned($random(seed)) % BINS;
            sendEvent(pix, bin);
        end
        runFrame(1'b1, 1'b0);
        if (timeouts != 0) return;
        // even pixels peak in bin 0, odd ones in the top bin
        for (pix = 0; pix < PIXELS && timeouts == 0; pix++) begin
            if (pix % 2 == 0) begin
                repeat (3) sendEvent(pix, 0);
                sendEvent(pix, 7);
            end else begin
                repeat (3) sendEvent(pix, BINS - 1);
                repeat (2) sendEvent(pix, BINS - 2);
            end
        end
        runFrame(1'b1, 1'b0);
        if (timeouts != 0) return;
        repeat (300) sendEvent(3, 20);
        repeat (60) sendEvent(3, 4);    // wins only if bin 20 wrapped
        runFrame(1'b1, 1'b0);
        if (timeouts != 0) return;
        runFrame(1'b1, 1'b1);           // empty frame, events arrive during its scan
        if (timeouts != 0) return;
        runFrame(1'b1, 1'b0);
    endtask

    initial begin
        clk = 1'b0;
        res = 1'b0;
        eventValid = 1'b0;
        eventPixel = '0;
        eventBin = '0;
        frameEnd = 1'b0;
        frameStart = 1'b0;
        checkOn = 1'b0;
        checkErrors = 0;
        timeouts = 0;
        seed = 32'hd16b;
        repeat (3) @(posedge clk);
        res <= 1'b1;
        @(posedge clk);
        runTests();
        $display("checks failed: %0d, timeouts: %0d", checkErrors, timeouts);
        if (checkErrors == 0 && timeouts == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: hw/sifhTop.sv
module sifhTop #(
    parameter int NB = sifhPkg::nb,
    parameter int NP = sifhPkg::np,
    parameter int PIXEL_NUM = sifhPkg::pixelNum,
    parameter int COUNT_W = sifhPkg::countW
) (
    input  logic clk,
    input  logic res,
    input  logic eventValid,
    input  logic [$clog2(PIXEL_NUM)-1:0] eventPixel,
    input  logic [NB-1:0] eventBin,
    output logic busy,
    input  logic frameEnd,
    output logic resultValid,
    output logic [$clog2(PIXEL_NUM)-1:0] resultPixel,
    output logic [NP-1:0] thMinus,
    output logic [NP-1:0] thPlus,
    output logic [NP-1:0] delta,
    output logic frameDone
);

    localparam int ADDR_W = $clog2(PIXEL_NUM) + NB;

    logic peakDone;
    logic [NB-1:0] peakCh;
    logic [$clog2(PIXEL_NUM)-1:0] peakPixel;

    ramBusIf #(.ADDR_W(ADDR_W), .DATA_W(COUNT_W)) accBus ();
    ramBusIf #(.ADDR_W(ADDR_W), .DATA_W(COUNT_W)) scanBus ();
    ramBusIf #(.ADDR_W(ADDR_W), .DATA_W(COUNT_W)) ramPort ();

    histAccumulator #(.NB(NB), .PIXEL_NUM(PIXEL_NUM), .COUNT_W(COUNT_W)) acc0 (
        .clk(clk), .res(res), .eventValid(eventValid), .eventPixel(eventPixel),
        .eventBin(eventBin), .busy(busy), .bus(accBus.requester)
    );

    peakFinder #(.NB(NB), .PIXEL_NUM(PIXEL_NUM), .COUNT_W(COUNT_W)) scan0 (
        .clk(clk), .res(res), .frameEnd(frameEnd), .bus(scanBus.requester),
        .peakDone(peakDone), .peakCh(peakCh), .peakPixel(peakPixel), .frameDone(frameDone)
    );

    ramArbiter arb0 (
        .clk(clk), .res(res), .accBus(accBus.arbiter), .scanBus(scanBus.arbiter),
        .ramPort(ramPort.requester)
    );

    histRam #(.ADDR_W(ADDR_W), .DATA_W(COUNT_W)) ram0 (
        .clk(clk), .port(ramPort.arbiter)
    );

    thresholdCalc #(.NB(NB), .NP(NP), .PIXEL_NUM(PIXEL_NUM)) th0 (
        .clk(clk), .res(res), .peakDone(peakDone), .peakCh(peakCh), .peakPixel(peakPixel),
        .resultValid(resultValid), .resultPixel(resultPixel), .thMinus(thMinus),
        .thPlus(thPlus), .delta(delta)
    );

endmodule

// File: hw/thresholdCalc.sv
module thresholdCalc #(
    parameter int NB = sifhPkg::nb,
    parameter int NP = sifhPkg::np,
    parameter int PIXEL_NUM = sifhPkg::pixelNum
) (
    input  logic clk,
    input  logic res,
    input  logic peakDone,
    input  logic [NB-1:0] peakCh,
    input  logic [$clog2(PIXEL_NUM)-1:0] peakPixel,
    output logic resultValid,
    output logic [$clog2(PIXEL_NUM)-1:0] resultPixel,
    output logic [NP-1:0] thMinus,
    output logic [NP-1:0] thPlus,
    output logic [NP-1:0] delta
);

    // half window, three quarters of the bin range
    localparam int SB = 2 ** (NB - 1) + 2 ** (NB - 2);
    localparam logic [NP-1:0] SB_W = NP'(SB);
    localparam logic [NP-1:0] WIN_W = NP'(2 * SB);
    localparam logic [NP-1:0] MAX_VAL = '1;

    logic [NP-1:0] ch;
    logic [NP-1:0] lo;
    logic [NP-1:0] hi;
    logic [NP:0] sum;       // one extra bit for the centre

    // peak bin scaled to threshold precision
    assign ch = NP'(peakCh) << (NP - NB);

    always_comb begin
        if (ch <= SB_W) begin
            lo = '0;                        // clamp at the bottom
            hi = WIN_W;
        end else if (ch >= MAX_VAL - SB_W) begin
            hi = MAX_VAL;                   // clamp at the top
            lo = MAX_VAL - WIN_W;
        end else begin
            lo = ch - SB_W;
            hi = ch + SB_W;
        end
    end

    assign sum = {1'b0, lo} + {1'b0, hi};

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            resultValid <= 1'b0;
        end else begin
            resultValid <= peakDone;
        end
    end

    always_ff @(posedge clk) begin
        if (peakDone) begin
            resultPixel <= peakPixel;
            thMinus <= lo;
            thPlus <= hi;
            delta <= sum[NP:1];
        end
    end

    assert property (@(posedge clk) disable iff (!res) resultValid |-> thMinus <= thPlus)
        else $error("thresholdCalc: thMinus %h above thPlus %h", thMinus, thPlus);

endmodule

// File: hw/peakFinder.sv
module peakFinder #(
    parameter int NB = sifhPkg::nb,
    parameter int PIXEL_NUM = sifhPkg::pixelNum,
    parameter int COUNT_W = sifhPkg::countW
) (
    input  logic clk,
    input  logic res,
    input  logic frameEnd,
    ramBusIf.requester bus,
    output logic peakDone,
    output logic [NB-1:0] peakCh,
    output logic [$clog2(PIXEL_NUM)-1:0] peakPixel,
    output logic frameDone
);

    localparam int PIXEL_W = $clog2(PIXEL_NUM);
    localparam logic [PIXEL_W-1:0] LAST_PIX = PIXEL_W'(PIXEL_NUM - 1);

    localparam logic [1:0] IDLE = 2'd0;
    localparam logic [1:0] READ = 2'd1;
    localparam logic [1:0] CLEAR = 2'd2;

    logic [1:0] state;
    logic scanning;
    logic [PIXEL_W-1:0] pixCnt;
    logic [NB-1:0] binCnt;
    logic [COUNT_W-1:0] runMax;
    logic [NB-1:0] runBin;
    logic takeNew;
    logic lastPix;      // current peakDone belongs to the last pixel
    logic lastDly;

    assign scanning = (state != IDLE);

    // strict compare, lowest bin wins a tie
    assign takeNew = (binCnt == '0) || (bus.rdata > runMax);

    assign bus.req = scanning;             // every scan cycle asks for the RAM
    assign bus.we = (state == CLEAR);      // zero write behind each read
    assign bus.addr = {pixCnt, binCnt};
    assign bus.wdata = '0;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state <= IDLE;
            pixCnt <= '0;
            binCnt <= '0;
            peakDone <= 1'b0;
            lastPix <= 1'b0;
            lastDly <= 1'b0;
            frameDone <= 1'b0;
        end else begin
            peakDone <= 1'b0;
            lastDly <= peakDone & lastPix;
            frameDone <= lastDly;           // one cycle after the last result
            case (state)
                IDLE: if (frameEnd) begin
                    pixCnt <= '0;
                    binCnt <= '0;
                    state <= READ;
                end
                READ: if (bus.gnt) state <= CLEAR;
                CLEAR: if (bus.gnt) begin
                    binCnt <= binCnt + NB'(1);
                    state <= READ;
                    if (binCnt == '1) begin
                        peakDone <= 1'b1;
                        lastPix <= (pixCnt == LAST_PIX);
                        pixCnt <= pixCnt + PIXEL_W'(1);
                        if (pixCnt == LAST_PIX) state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // running maximum and peak outputs
    always_ff @(posedge clk) begin
        if (state == CLEAR && bus.gnt) begin
            runMax <= takeNew ? bus.rdata : runMax;
            runBin <= takeNew ? binCnt : runBin;
            if (binCnt == '1) begin
                peakCh <= takeNew ? binCnt : runBin;
                peakPixel <= pixCnt;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!res) peakDone |=> !peakDone)
        else $error("peakFinder: peakDone longer than one cycle");

endmodule

// File: hw/histAccumulator.sv
module histAccumulator #(
    parameter int NB = sifhPkg::nb,
    parameter int PIXEL_NUM = sifhPkg::pixelNum,
    parameter int COUNT_W = sifhPkg::countW
) (
    input  logic clk,
    input  logic res,
    input  logic eventValid,
    input  logic [$clog2(PIXEL_NUM)-1:0] eventPixel,
    input  logic [NB-1:0] eventBin,
    output logic busy,
    ramBusIf.requester bus
);

    localparam int PIXEL_W = $clog2(PIXEL_NUM);

    localparam logic [1:0] IDLE = 2'd0;
    localparam logic [1:0] RD = 2'd1;
    localparam logic [1:0] WR = 2'd2;

    logic [1:0] state;
    logic [PIXEL_W+NB-1:0] addrQ;
    logic [COUNT_W-1:0] incCount;

    assign busy = (state != IDLE);

    // saturate instead of wrapping
    assign incCount = (bus.rdata == '1) ? bus.rdata : bus.rdata + COUNT_W'(1);

    assign bus.req = (state == RD) || (state == WR);
    assign bus.we = (state == WR);
    assign bus.addr = addrQ;
    assign bus.wdata = incCount;    // rdata is valid while in WR

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: if (eventValid) state <= RD;
                RD: if (bus.gnt) state <= WR;
                WR: if (bus.gnt) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // latch the event address on acceptance
    always_ff @(posedge clk) begin
        if (state == IDLE && eventValid) begin
            addrQ <= {eventPixel, eventBin};
        end
    end

    assert property (@(posedge clk) disable iff (!res) $rose(eventValid) |-> !busy)
        else $error("histAccumulator: eventValid rose while busy");

endmodule

// File: hw/ramArbiter.sv
module ramArbiter (
    input logic clk,
    input logic res,
    ramBusIf.arbiter accBus,
    ramBusIf.arbiter scanBus,
    ramBusIf.requester ramPort
);

    logic accSel;
    logic scanSel;
    logic accOwn;       // acc held the RAM last cycle
    logic scanOwn;      // scanner held the RAM last cycle
    logic lastRead;     // last granted access was a read
    logic scanLock;

    // a scanner read keeps the RAM for its clearing write,
    // so no increment can slip between read and clear
    assign scanLock = scanOwn & lastRead & scanBus.req;

    assign accSel = accBus.req & ~scanLock;    // fixed priority otherwise
    assign scanSel = scanBus.req & ~accSel;

    assign ramPort.req = accSel | scanSel;
    assign ramPort.we = accSel ? accBus.we : scanBus.we;
    assign ramPort.addr = accSel ? accBus.addr : scanBus.addr;
    assign ramPort.wdata = accSel ? accBus.wdata : scanBus.wdata;

    assign accBus.gnt = accSel & ramPort.gnt;
    assign scanBus.gnt = scanSel & ramPort.gnt;

    // read data goes to whoever owned the previous cycle
    assign accBus.rdata = accOwn ? ramPort.rdata : '0;
    assign scanBus.rdata = scanOwn ? ramPort.rdata : '0;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            accOwn <= 1'b0;
            scanOwn <= 1'b0;
            lastRead <= 1'b0;
        end else begin
            accOwn <= accBus.gnt;
            scanOwn <= scanBus.gnt;
            lastRead <= ramPort.gnt & ~ramPort.we;
        end
    end

    assert property (@(posedge clk) disable iff (!res) !(accBus.gnt && scanBus.gnt))
        else $error("ramArbiter: both requesters granted");

    // a scanner read is always followed by its own write
    assert property (@(posedge clk) disable iff (!res)
        (scanBus.gnt && !scanBus.we) |=> (scanBus.gnt && scanBus.we))
        else $error("ramArbiter: scanner clear write was not granted");

endmodule

// File: hw/histRam.sv
module histRam #(
    parameter int ADDR_W = sifhPkg::addrW,
    parameter int DATA_W = sifhPkg::countW
) (
    input logic clk,
    ramBusIf.arbiter port
);

    localparam int DEPTH = 2 ** ADDR_W;

    logic [DATA_W-1:0] mem [DEPTH];
    logic [DATA_W-1:0] rdataQ;

    // single port, every request is served at once
    assign port.gnt = port.req;
    assign port.rdata = rdataQ;

    // read-before-write on the same access
    always_ff @(posedge clk) begin
        if (port.req) begin
            if (port.we) begin
                mem[port.addr] <= port.wdata;
            end
            rdataQ <= mem[port.addr];
        end
    end

    // a granted access never leaves the address undefined
    assert property (@(posedge clk) port.req |-> !$isunknown(port.addr))
        else $error("histRam: request with unknown address");

endmodule

// File: hw/ramBusIf.sv
interface ramBusIf #(
    parameter int ADDR_W = sifhPkg::addrW,
    parameter int DATA_W = sifhPkg::countW
) ();

    // request side
    logic req;
    logic we;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;

    // response side
    logic gnt;                      // access happens in this cycle
    logic [DATA_W-1:0] rdata;       // valid the cycle after gnt

    modport requester (
        output req,
        output we,
        output addr,
        output wdata,
        input  gnt,
        input  rdata
    );

    modport arbiter (
        input  req,
        input  we,
        input  addr,
        input  wdata,
        output gnt,
        output rdata
    );

endinterface

// File: hw/sifhPkg.sv
package sifhPkg;

    // histogram geometry
    localparam int nb = 5;          // bin index width, 32 bins per pixel
    localparam int np = 12;         // threshold precision
    localparam int pixelNum = 8;    // pixels sharing one RAM
    localparam int countW = 8;      // saturating bin count

    // derived widths
    localparam int pixelW = $clog2(pixelNum);
    localparam int addrW = pixelW + nb;

    // pixel index
    typedef logic [pixelW-1:0] pixelT;

    // bin index within a pixel
    typedef logic [nb-1:0] binT;

    // one histogram word
    typedef logic [countW-1:0] countT;

    // RAM address, pixel in the upper bits
    typedef logic [addrW-1:0] addrT;

    // window bounds and centre
    typedef logic [np-1:0] thT;

endpackage
